// ==== design/la_pkg.sv ====
package la_pkg;

    // one register bus transaction, passed stage to stage
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] rdata;
        logic        rw;
        logic        valid;
    } la_bus_t;

    // probe bundle, also the stored sample word
    typedef struct packed {
        logic       flag_a;
        logic       flag_b;
        logic       flag_c;
        logic [3:0] nibble;
    } la_probes_t;

    typedef enum logic [3:0] {
        DISABLE  = 4'd0,
        RISING   = 4'd1,
        FALLING  = 4'd2,
        CHANGING = 4'd3,
        GT       = 4'd4,
        LT       = 4'd5,
        GEQ      = 4'd6,
        LEQ      = 4'd7,
        EQ       = 4'd8,
        NEQ      = 4'd9
    } la_trig_op_e;

    typedef enum logic [3:0] {
        IDLE             = 4'd0,
        MOVE_TO_POSITION = 4'd1,
        IN_POSITION      = 4'd2,
        CAPTURING        = 4'd3,
        CAPTURED         = 4'd4
    } la_state_e;

    // register file to capture controller
    typedef struct packed {
        logic [15:0] trigger_loc;
        logic        request_start;
        logic        request_stop;
    } la_ctrl_t;

    // capture controller back to register file
    typedef struct packed {
        la_state_e   state;
        logic [15:0] current_loc;
        logic [15:0] read_pointer;
    } la_status_t;

    localparam int          LA_SAMPLE_DEPTH = 128;
    localparam logic [15:0] LA_CTRL_BASE    = 16'd0;
    localparam logic [15:0] LA_TRIG_BASE    = 16'd6;
    localparam logic [15:0] LA_MEM_BASE     = 16'd14;

endpackage

// ==== design/la_trigger.sv ====
`timescale 1ns/100ps

module la_trigger import la_pkg::*; #(
    parameter type probe_t = logic
) (
    input  logic        clk,
    input  logic        reset_i,
    input  probe_t      probe_i,
    input  la_trig_op_e op_i,
    input  probe_t      arg_i,
    output logic        trig_o
);

    probe_t probe_prev;

    // last cycle's probe value for the edge ops
    always_ff @(posedge clk) begin
        if (reset_i) begin
            probe_prev <= '0;
        end else begin
            probe_prev <= probe_i;
        end
    end

    always_comb begin
        case (op_i)
            RISING:   trig_o = probe_i > probe_prev;
            FALLING:  trig_o = probe_i < probe_prev;
            CHANGING: trig_o = probe_i != probe_prev;
            GT:       trig_o = probe_i > arg_i;
            LT:       trig_o = probe_i < arg_i;
            GEQ:      trig_o = probe_i >= arg_i;
            LEQ:      trig_o = probe_i <= arg_i;
            EQ:       trig_o = probe_i == arg_i;
            NEQ:      trig_o = probe_i != arg_i;
            // DISABLE and the unused codes
            default:  trig_o = 1'b0;
        endcase
    end

endmodule

// ==== design/la_trigger_block.sv ====
`timescale 1ns/100ps

module la_trigger_block import la_pkg::*; #(
    parameter logic [15:0] BASE_ADDR = LA_TRIG_BASE
) (
    input  logic       clk,
    input  logic       reset_i,
    input  la_probes_t probes_i,
    input  la_bus_t    bus_i,
    output la_bus_t    bus_o,
    output logic       trig_o
);

    // per probe op, order flag_a, flag_b, flag_c, nibble
    la_trig_op_e op_q [4];
    // args share the probe layout so each field has its own width
    la_probes_t  arg_q;

    logic [15:0] offset;
    logic        in_window;
    logic        trig_a;
    logic        trig_b;
    logic        trig_c;
    logic        trig_n;

    assign offset    = bus_i.addr - BASE_ADDR;
    assign in_window = (bus_i.addr >= BASE_ADDR) && (offset < 16'd8);

    always_ff @(posedge clk) begin
        bus_o <= bus_i;
        if (reset_i) begin
            bus_o.valid <= 1'b0;
            op_q        <= '{default: DISABLE};
            arg_q       <= '0;
        end else if (bus_i.valid && in_window) begin
            if (bus_i.rw) begin
                case (offset[2:0])
                    3'd0: op_q[0] <= la_trig_op_e'(bus_i.wdata[3:0]);
                    3'd1: arg_q.flag_a <= bus_i.wdata[0];
                    3'd2: op_q[1] <= la_trig_op_e'(bus_i.wdata[3:0]);
                    3'd3: arg_q.flag_b <= bus_i.wdata[0];
                    3'd4: op_q[2] <= la_trig_op_e'(bus_i.wdata[3:0]);
                    3'd5: arg_q.flag_c <= bus_i.wdata[0];
                    3'd6: op_q[3] <= la_trig_op_e'(bus_i.wdata[3:0]);
                    default: arg_q.nibble <= bus_i.wdata[3:0];
                endcase
            end else begin
                case (offset[2:0])
                    3'd0: bus_o.rdata <= {12'd0, op_q[0]};
                    3'd1: bus_o.rdata <= {15'd0, arg_q.flag_a};
                    3'd2: bus_o.rdata <= {12'd0, op_q[1]};
                    3'd3: bus_o.rdata <= {15'd0, arg_q.flag_b};
                    3'd4: bus_o.rdata <= {12'd0, op_q[2]};
                    3'd5: bus_o.rdata <= {15'd0, arg_q.flag_c};
                    3'd6: bus_o.rdata <= {12'd0, op_q[3]};
                    default: bus_o.rdata <= {12'd0, arg_q.nibble};
                endcase
            end
        end
    end

    la_trigger #(.probe_t(logic)) i_trig_a (
        .clk     (clk),
        .reset_i (reset_i),
        .probe_i (probes_i.flag_a),
        .op_i    (op_q[0]),
        .arg_i   (arg_q.flag_a),
        .trig_o  (trig_a)
    );

    la_trigger #(.probe_t(logic)) i_trig_b (
        .clk     (clk),
        .reset_i (reset_i),
        .probe_i (probes_i.flag_b),
        .op_i    (op_q[1]),
        .arg_i   (arg_q.flag_b),
        .trig_o  (trig_b)
    );

    la_trigger #(.probe_t(logic)) i_trig_c (
        .clk     (clk),
        .reset_i (reset_i),
        .probe_i (probes_i.flag_c),
        .op_i    (op_q[2]),
        .arg_i   (arg_q.flag_c),
        .trig_o  (trig_c)
    );

    la_trigger #(.probe_t(logic [3:0])) i_trig_n (
        .clk     (clk),
        .reset_i (reset_i),
        .probe_i (probes_i.nibble),
        .op_i    (op_q[3]),
        .arg_i   (arg_q.nibble),
        .trig_o  (trig_n)
    );

    // any probe can fire the capture
    assign trig_o = trig_a | trig_b | trig_c | trig_n;

endmodule

// ==== design/la_ctrl_regs.sv ====
`timescale 1ns/100ps

module la_ctrl_regs import la_pkg::*; #(
    parameter logic [15:0] BASE_ADDR = LA_CTRL_BASE
) (
    input  logic       clk,
    input  logic       reset_i,
    input  la_bus_t    bus_i,
    output la_bus_t    bus_o,
    output la_ctrl_t   ctrl_o,
    input  la_status_t status_i
);

    logic [15:0] offset;
    logic        in_window;

    assign offset    = bus_i.addr - BASE_ADDR;
    assign in_window = (bus_i.addr >= BASE_ADDR) && (offset < 16'd6);

    always_ff @(posedge clk) begin
        bus_o <= bus_i;
        if (reset_i) begin
            bus_o.valid          <= 1'b0;
            ctrl_o.trigger_loc   <= '0;
            ctrl_o.request_start <= 1'b0;
            ctrl_o.request_stop  <= 1'b0;
        end else if (bus_i.valid && in_window) begin
            if (bus_i.rw) begin
                // state, current_loc and read_pointer ignore writes
                case (offset[2:0])
                    3'd1: ctrl_o.trigger_loc <= bus_i.wdata;
                    3'd3: ctrl_o.request_start <= bus_i.wdata[0];
                    3'd4: ctrl_o.request_stop <= bus_i.wdata[0];
                    default: ;
                endcase
            end else begin
                case (offset[2:0])
                    3'd0: bus_o.rdata <= {12'd0, status_i.state};
                    3'd1: bus_o.rdata <= ctrl_o.trigger_loc;
                    3'd2: bus_o.rdata <= status_i.current_loc;
                    3'd3: bus_o.rdata <= {15'd0, ctrl_o.request_start};
                    3'd4: bus_o.rdata <= {15'd0, ctrl_o.request_stop};
                    default: bus_o.rdata <= status_i.read_pointer;
                endcase
            end
        end
    end

endmodule

// ==== design/la_capture_ctrl.sv ====
`timescale 1ns/100ps

module la_capture_ctrl import la_pkg::*; #(
    parameter int SAMPLE_DEPTH = LA_SAMPLE_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  la_ctrl_t                        ctrl_i,
    input  logic                            trig_i,
    output la_status_t                      status_o,
    output logic [$clog2(SAMPLE_DEPTH)-1:0] wr_addr_o,
    output logic                            wr_en_o
);

    localparam int          AW   = $clog2(SAMPLE_DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(SAMPLE_DEPTH);

    la_state_e   state;
    logic [15:0] current_loc;
    // extra msb on both pointers tells full from empty
    logic [AW:0] write_ptr;
    logic [AW:0] read_ptr;
    logic [AW:0] fill;
    logic        prev_start;
    logic        prev_stop;
    logic        start_edge;
    logic        stop_edge;

    assign start_edge = ctrl_i.request_start & ~prev_start;
    assign stop_edge  = ctrl_i.request_stop & ~prev_stop;
    assign fill       = write_ptr - read_ptr;
    assign wr_addr_o  = write_ptr[AW-1:0];

    // current probes are written on the same edge
    always_comb begin
        case (state)
            MOVE_TO_POSITION, IN_POSITION: wr_en_o = 1'b1;
            CAPTURING:                     wr_en_o = (fill != FULL);
            default:                       wr_en_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            current_loc <= '0;
            write_ptr   <= '0;
            read_ptr    <= '0;
            prev_start  <= 1'b0;
            prev_stop   <= 1'b0;
        end else begin
            prev_start <= ctrl_i.request_start;
            prev_stop  <= ctrl_i.request_stop;
            if (wr_en_o) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (stop_edge) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE, CAPTURED: begin
                        if (start_edge) begin
                            // empty the buffer
                            read_ptr    <= write_ptr;
                            current_loc <= '0;
                            state <= (ctrl_i.trigger_loc == 16'd0) ? IN_POSITION
                                                                   : MOVE_TO_POSITION;
                        end
                    end
                    MOVE_TO_POSITION: begin
                        current_loc <= current_loc + 16'd1;
                        if (current_loc + 16'd1 == ctrl_i.trigger_loc) begin
                            state <= IN_POSITION;
                        end
                    end
                    IN_POSITION: begin
                        // sliding window of trigger_loc samples until the trigger
                        if (trig_i) begin
                            state <= CAPTURING;
                        end else begin
                            read_ptr <= read_ptr + 1'b1;
                        end
                    end
                    CAPTURING: begin
                        if (fill == FULL) begin
                            state <= CAPTURED;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    assign status_o.state        = state;
    assign status_o.current_loc  = current_loc;
    assign status_o.read_pointer = 16'(read_ptr[AW-1:0]);

endmodule

// ==== design/la_sample_mem.sv ====
`timescale 1ns/100ps

module la_sample_mem import la_pkg::*; #(
    parameter logic [15:0] BASE_ADDR    = LA_MEM_BASE,
    parameter int          SAMPLE_DEPTH = LA_SAMPLE_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  la_bus_t                         bus_i,
    output la_bus_t                         bus_o,
    input  logic [$clog2(SAMPLE_DEPTH)-1:0] wr_addr_i,
    input  logic                            wr_en_i,
    input  la_probes_t                      wr_data_i
);

    localparam int AW = $clog2(SAMPLE_DEPTH);

    la_probes_t  mem [SAMPLE_DEPTH];

    logic [15:0] offset;
    logic        in_window;
    logic [AW-1:0] rd_addr;

    assign offset    = bus_i.addr - BASE_ADDR;
    assign in_window = (bus_i.addr >= BASE_ADDR) && (offset < 16'(SAMPLE_DEPTH));
    assign rd_addr   = offset[AW-1:0];

    // capture side write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // bus side is read only, writes in the window just pass through
    always_ff @(posedge clk) begin
        bus_o <= bus_i;
        if (reset_i) begin
            bus_o.valid <= 1'b0;
        end else if (bus_i.valid && !bus_i.rw && in_window) begin
            bus_o.rdata <= 16'(mem[rd_addr]);
        end
    end

endmodule

// ==== design/logic_analyzer.sv ====
`timescale 1ns/100ps

module logic_analyzer import la_pkg::*; #(
    parameter int SAMPLE_DEPTH = LA_SAMPLE_DEPTH
) (
    input  logic       clk,
    input  logic       reset_i,
    input  la_probes_t probes_i,
    input  la_bus_t    bus_i,
    output la_bus_t    bus_o
);

    localparam int AW = $clog2(SAMPLE_DEPTH);

    la_bus_t    bus_ctrl_trig;
    la_bus_t    bus_trig_mem;
    la_ctrl_t   ctrl;
    la_status_t status;
    logic       trig;
    logic [AW-1:0] wr_addr;
    logic       wr_en;

    // bus chain: control regs, triggers, then sample memory
    la_ctrl_regs #(.BASE_ADDR(LA_CTRL_BASE)) i_ctrl_regs (
        .clk      (clk),
        .reset_i  (reset_i),
        .bus_i    (bus_i),
        .bus_o    (bus_ctrl_trig),
        .ctrl_o   (ctrl),
        .status_i (status)
    );

    la_trigger_block #(.BASE_ADDR(LA_TRIG_BASE)) i_trigger_block (
        .clk      (clk),
        .reset_i  (reset_i),
        .probes_i (probes_i),
        .bus_i    (bus_ctrl_trig),
        .bus_o    (bus_trig_mem),
        .trig_o   (trig)
    );

    la_capture_ctrl #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) i_capture_ctrl (
        .clk       (clk),
        .reset_i   (reset_i),
        .ctrl_i    (ctrl),
        .trig_i    (trig),
        .status_o  (status),
        .wr_addr_o (wr_addr),
        .wr_en_o   (wr_en)
    );

    la_sample_mem #(
        .BASE_ADDR    (LA_MEM_BASE),
        .SAMPLE_DEPTH (SAMPLE_DEPTH)
    ) i_sample_mem (
        .clk       (clk),
        .reset_i   (reset_i),
        .bus_i     (bus_trig_mem),
        .bus_o     (bus_o),
        .wr_addr_i (wr_addr),
        .wr_en_i   (wr_en),
        .wr_data_i (probes_i)
    );

endmodule

// ==== dv/tb_logic_analyzer.sv ====
`timescale 1ns/100ps

module tb_logic_analyzer import la_pkg::*; ();

    localparam int DEPTH         = LA_SAMPLE_DEPTH;
    localparam int ACCESS_CYCLES = 4;
    localparam int PIPE_COUNT    = 16;
    localparam int FIRST_FREE    = LA_MEM_BASE + LA_SAMPLE_DEPTH;
    // positioning, trigger wait and fill each take at most DEPTH cycles
    localparam int CAPTURE_CYCLES = (DEPTH + 24) * ACCESS_CYCLES + 3 * DEPTH;
    localparam int TEST_CYCLES    = 24 * ACCESS_CYCLES + (PIPE_COUNT + 4) + 4 * CAPTURE_CYCLES;
    localparam int TIMEOUT_CYCLES = 20 * TEST_CYCLES;

    logic        clk;
    logic        reset_i;
    la_probes_t  probes_i;
    la_bus_t     bus_i;
    la_bus_t     bus_o;

    logic [6:0]  probe_cnt;
    logic [31:0] lfsr_q;
    logic [15:0] samples [DEPTH];
    int          errors;
    int          checks;
    int          cycle_count = 0;

    logic_analyzer #(.SAMPLE_DEPTH(DEPTH)) i_dut (
        .clk      (clk),
        .reset_i  (reset_i),
        .probes_i (probes_i),
        .bus_i    (bus_i),
        .bus_o    (bus_o)
    );

    always #20 clk = ~clk;

    // free running probe counter, one step per cycle
    always @(posedge clk) begin
        #2;
        probe_cnt <= probe_cnt + 7'd1;
    end

    assign probes_i = probe_cnt;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            value  = {value[30:0], lfsr_q[0]};
        end
        return value;
    endfunction

    function automatic logic [3:0] field_of(input logic [6:0] s, input int field);
        case (field)
            0:       return {3'd0, s[6]};
            1:       return {3'd0, s[5]};
            2:       return {3'd0, s[4]};
            default: return s[3:0];
        endcase
    endfunction

    // reference trigger behaviour
    function automatic logic trig_model(input la_trig_op_e op, input logic [3:0] cur,
                                        input logic [3:0] prev, input logic [3:0] arg);
        case (op)
            RISING:   return cur > prev;
            FALLING:  return cur < prev;
            CHANGING: return cur != prev;
            GT:       return cur > arg;
            LT:       return cur < arg;
            GEQ:      return cur >= arg;
            LEQ:      return cur <= arg;
            EQ:       return cur == arg;
            NEQ:      return cur != arg;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    // response is back on bus_o three edges after the request
    task automatic bus_access(input logic rw, input logic [15:0] addr,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clk);
        #2;
        bus_i.addr  = addr;
        bus_i.wdata = wdata;
        bus_i.rdata = 16'd0;
        bus_i.rw    = rw;
        bus_i.valid = 1'b1;
        @(posedge clk);
        #2;
        bus_i.valid = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        compare(bus_o.valid, 1'b1, "bus response valid");
        rdata = bus_o.rdata;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [15:0] data);
        bus_access(1'b0, addr, 16'd0, data);
    endtask

    task automatic set_trigger(input int field, input la_trig_op_e op, input logic [3:0] arg);
        write_reg(LA_TRIG_BASE + 16'(2 * field), {12'd0, op});
        write_reg(LA_TRIG_BASE + 16'(2 * field + 1), {12'd0, arg});
    endtask

    task automatic clear_triggers();
        for (int i = 0; i < 8; i++) begin
            write_reg(LA_TRIG_BASE + 16'(i), 16'd0);
        end
    endtask

    task automatic start_capture(input int tl);
        write_reg(LA_CTRL_BASE + 16'd1, 16'(tl));
        write_reg(LA_CTRL_BASE + 16'd3, 16'd1);
        write_reg(LA_CTRL_BASE + 16'd3, 16'd0);
    endtask

    task automatic wait_state(input la_state_e target);
        logic [15:0] st;
        read_reg(LA_CTRL_BASE, st);
        while (st != 16'(target)) begin
            read_reg(LA_CTRL_BASE, st);
        end
    endtask

    // read the whole buffer into logical order and check it
    task automatic check_capture(input int field, input la_trig_op_e op,
                                 input logic [3:0] arg, input int tl);
        logic [15:0] rp;
        logic [15:0] word;
        logic [6:0]  cur_s;
        logic [6:0]  prev_s;
        read_reg(LA_CTRL_BASE + 16'd5, rp);
        compare(rp < DEPTH, 1'b1, "read pointer inside the buffer");
        for (int i = 0; i < DEPTH; i++) begin
            read_reg(LA_MEM_BASE + 16'(i), word);
            samples[(i + DEPTH - int'(rp % DEPTH)) % DEPTH] = word;
        end
        compare(samples[0][15:7], 0, "sample zero extension");
        for (int k = 1; k < DEPTH; k++) begin
            compare(samples[k], {9'd0, samples[k-1][6:0] + 7'd1},
                    $sformatf("logical sample %0d follows its predecessor", k));
        end
        cur_s  = samples[tl][6:0];
        // before index 0 the counter still defines the previous probe value
        prev_s = (tl > 0) ? samples[tl-1][6:0] : cur_s - 7'd1;
        compare(trig_model(op, field_of(cur_s, field), field_of(prev_s, field), arg), 1'b1,
                $sformatf("sample at trigger_loc %0d meets op %0d", tl, op));
        if (op == EQ && tl > 0) begin
            compare(trig_model(op, field_of(prev_s, field), 4'd0, arg), 1'b0,
                    "sample before the trigger does not match");
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        $display("%s finished with %0d error(s)", name, errors - start_errors);
    endtask

    task automatic test_register_readback();
        logic [15:0] wvals [9];
        logic [15:0] mask;
        logic [15:0] rdata;
        int          start_errors;
        start_errors = errors;
        compare(bus_o.valid, 1'b0, "bus output idle after reset");
        read_reg(LA_CTRL_BASE, rdata);
        compare(rdata, 16'(IDLE), "state after reset");
        read_reg(LA_CTRL_BASE + 16'd5, rdata);
        compare(rdata, 0, "read pointer after reset");
        for (int i = 0; i < 9; i++) begin
            wvals[i] = 16'(take_bits(16));
        end
        write_reg(LA_CTRL_BASE + 16'd1, wvals[0]);
        for (int i = 0; i < 8; i++) begin
            write_reg(LA_TRIG_BASE + 16'(i), wvals[i+1]);
        end
        read_reg(LA_CTRL_BASE + 16'd1, rdata);
        compare(rdata, wvals[0], "trigger_loc readback");
        for (int i = 0; i < 8; i++) begin
            // ops and the nibble arg are 4 bits, flag args 1 bit
            mask = (i % 2 == 0 || i == 7) ? 16'h000f : 16'h0001;
            read_reg(LA_TRIG_BASE + 16'(i), rdata);
            compare(rdata, wvals[i+1] & mask, $sformatf("trigger register %0d readback", i));
        end
        finish_test("register readback", start_errors);
    endtask

    task automatic test_bus_pipeline();
        la_bus_t sent [PIPE_COUNT];
        int      start_errors;
        start_errors = errors;
        for (int k = 0; k < PIPE_COUNT + 4; k++) begin
            @(posedge clk);
            #2;
            if (k == 2 || k == PIPE_COUNT + 3) begin
                compare(bus_o.valid, 1'b0, "no transaction outside its slot");
            end else if (k >= 3) begin
                compare(bus_o, sent[k-3], $sformatf("pass-through transaction %0d", k - 3));
            end
            if (k < PIPE_COUNT) begin
                sent[k].addr  = 16'(FIRST_FREE + take_bits(16) % (65536 - FIRST_FREE));
                sent[k].wdata = 16'(take_bits(16));
                sent[k].rdata = 16'(take_bits(16));
                sent[k].rw    = 1'b0;
                sent[k].valid = 1'b1;
                bus_i = sent[k];
            end else begin
                bus_i.valid = 1'b0;
            end
        end
        finish_test("bus pipeline", start_errors);
    endtask

    task automatic test_compare_trigger();
        la_trig_op_e op;
        logic [3:0]  arg;
        int          tl;
        int          start_errors;
        start_errors = errors;
        clear_triggers();
        op  = take_bits(1) ? EQ : NEQ;
        arg = 4'(take_bits(4));
        tl  = int'(take_bits(7));
        set_trigger(3, op, arg);
        start_capture(tl);
        wait_state(CAPTURED);
        check_capture(3, op, arg, tl);
        finish_test("compare trigger capture", start_errors);
    endtask

    task automatic test_random_op();
        la_trig_op_e op;
        logic [3:0]  arg;
        logic [3:0]  max;
        int          field;
        int          tl;
        int          start_errors;
        start_errors = errors;
        clear_triggers();
        // RISING through LEQ are codes 1 to 7
        op    = la_trig_op_e'(4'(1 + take_bits(8) % 7));
        field = int'(take_bits(2));
        max   = (field == 3) ? 4'hf : 4'h1;
        // keep the condition reachable by the counter
        if (op == GT) begin
            arg = 4'(take_bits(4) % max);
        end else if (op == LT) begin
            arg = 4'(1 + take_bits(4) % max);
        end else begin
            arg = 4'(take_bits(4)) & max;
        end
        tl = int'(take_bits(7));
        set_trigger(field, op, arg);
        start_capture(tl);
        wait_state(CAPTURED);
        check_capture(field, op, arg, tl);
        finish_test("random operation capture", start_errors);
    endtask

    task automatic test_stop_restart();
        logic [15:0] rdata;
        logic [3:0]  arg;
        int          tl;
        int          start_errors;
        start_errors = errors;
        clear_triggers();
        tl = int'(1 + take_bits(7) % (DEPTH - 1));
        start_capture(tl);
        read_reg(LA_CTRL_BASE, rdata);
        while (rdata == 16'(MOVE_TO_POSITION)) begin
            read_reg(LA_CTRL_BASE, rdata);
        end
        compare(rdata, 16'(IN_POSITION), "state after positioning");
        read_reg(LA_CTRL_BASE + 16'd2, rdata);
        compare(rdata, 16'(tl), "current_loc after positioning");
        write_reg(LA_CTRL_BASE + 16'd4, 16'd1);
        read_reg(LA_CTRL_BASE, rdata);
        compare(rdata, 16'(IDLE), "state after stop");
        write_reg(LA_CTRL_BASE + 16'd4, 16'd0);
        arg = 4'(take_bits(4));
        tl  = int'(take_bits(7));
        set_trigger(3, EQ, arg);
        start_capture(tl);
        wait_state(CAPTURED);
        check_capture(3, EQ, arg, tl);
        finish_test("stop and restart", start_errors);
    endtask

    initial begin
        clk       = 1'b0;
        reset_i   = 1'b1;
        probe_cnt = 7'd0;
        bus_i     = '0;
        lfsr_q    = 32'h852e_5e9f;
        errors    = 0;
        checks    = 0;
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;

        test_register_readback();
        test_bus_pipeline();
        test_compare_trigger();
        test_random_op();
        test_stop_restart();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== logic_analyzer.f ====
design/la_pkg.sv
design/la_trigger.sv
design/la_trigger_block.sv
design/la_ctrl_regs.sv
design/la_capture_ctrl.sv
design/la_sample_mem.sv
design/logic_analyzer.sv
dv/tb_logic_analyzer.sv

// ==== Bender.yml ====
package:
  name: logic_analyzer

sources:
  - files:
      - design/la_pkg.sv
      - design/la_trigger.sv
      - design/la_trigger_block.sv
      - design/la_ctrl_regs.sv
      - design/la_capture_ctrl.sv
      - design/la_sample_mem.sv
      - design/logic_analyzer.sv
  - target: simulation
    files:
      - dv/tb_logic_analyzer.sv
